// File: Bender.yml
package:
  name: cpu_core

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/cpu_pkg.sv
      - logic/pipeStage.sv
      - logic/pipeControl.sv
      - logic/retireCounter.sv
      - logic/regFile.sv
      - logic/instDecode.sv
      - logic/execUnit.sv
      - logic/cpuCore.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - bench/cpuCore_assertions.sv
      - bench/cpuCore_tb.sv

// File: bench/cpuCore_assertions.sv
`default_nettype none

module cpuCore_assertions (
    input wire                 Clk,
    input wire                 rstN,
    input wire                 dmemRead,
    input wire                 dmemWrite,
    input wire                 imemRead,
    input wire cpu_pkg::word_t imemAddr,
    input wire                 isHalted,
    input wire cpu_pkg::word_t numInst
);

    // Number of failed checks
    int failCount;

    initial begin
        failCount = 0;
    end

    // One data memory access per cycle
    dmemExclusive: assert property (@(posedge Clk) disable iff (!rstN)
        !(dmemRead && dmemWrite))
        else begin
            failCount++;
            $error("dmemRead and dmemWrite are high together");
        end

    // A halted core neither fetches nor moves its pc
    noFetchWhenHalted: assert property (@(posedge Clk) disable iff (!rstN)
        isHalted |-> !imemRead && $stable(imemAddr))
        else begin
            failCount++;
            $error("fetch continued while the core is halted");
        end

    countFrozen: assert property (@(posedge Clk) disable iff (!rstN)
        isHalted |=> $stable(numInst))
        else begin
            failCount++;
            $error("numInst changed after halt");
        end

    // At most one instruction retires per cycle
    countStep: assert property (@(posedge Clk) disable iff (!rstN)
        (numInst == $past(numInst)) || (numInst == $past(numInst) + 16'd1))
        else begin
            failCount++;
            $error("numInst moved by more than one in a cycle");
        end

endmodule

`default_nettype wire

// File: bench/cpuCore_tb.sv
`default_nettype none
`include "cpu_consts.svh"

module cpuCore_tb;
    import cpu_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int RESET_CYCLES = 4;
    localparam int NUM_TESTS = 6;
    localparam int PROG_WORDS = 16;
    localparam int MAX_WWD = 4;
    localparam int SETTLE_CYCLES = 8;
    localparam int CYCLES_PER_TEST = 200;
    localparam logic [7:0] DATA_ADDR = 8'h10;

    logic Clk;
    logic rstN;
    logic imemRead;
    word_t imemAddr;
    word_t imemData;
    logic dmemRead;
    logic dmemWrite;
    word_t dmemAddr;
    word_t dmemWdata;
    word_t dmemRdata;
    logic isHalted;
    word_t numInst;
    word_t outputPort;

    word_t rom [PROG_WORDS];
    word_t ram [256];
    int curTest;

    string testName [NUM_TESTS];
    word_t progTab [NUM_TESTS][PROG_WORDS];
    int progLen [NUM_TESTS];
    word_t dataTab [NUM_TESTS];
    word_t wwdTab [NUM_TESTS][MAX_WWD];
    int wwdNum [NUM_TESTS];
    word_t countTab [NUM_TESTS];

    int valueErrors;
    int otherErrors;

    cpuCore u_cpuCore (
        .Clk, .rstN, .imemRead, .imemAddr, .imemData,
        .dmemRead, .dmemWrite, .dmemAddr, .dmemWdata, .dmemRdata,
        .isHalted, .numInst, .outputPort
    );

    bind cpuCore cpuCore_assertions u_assertions (
        .Clk, .rstN, .dmemRead, .dmemWrite, .imemRead, .imemAddr, .isHalted, .numInst
    );

    always #(CLK_PERIOD / 2) Clk = ~Clk;

    // Both memories answer in the same cycle
    assign imemData = rom[imemAddr[3:0]];
    assign dmemRdata = dmemRead ? ram[dmemAddr[7:0]] : 'x;

    // RAM is refilled during reset and then the preloaded word goes on top
    always @(posedge Clk) begin
        if (!rstN) begin
            for (int i = 0; i < 256; i++) begin
                ram[i] <= {i[7:0] ^ 8'hC3, i[7:0]};
            end
            ram[DATA_ADDR] <= dataTab[curTest];
        end else if (dmemWrite) begin
            ram[dmemAddr[7:0]] <= dmemWdata;
        end
    end

    function automatic word_t rType(input regIdx_t rs, input regIdx_t rt, input regIdx_t rd,
                                    input logic [5:0] fn);
        return {`OP_RTYPE, rs, rt, rd, fn};
    endfunction

    function automatic word_t iType(input logic [3:0] op, input regIdx_t rs, input regIdx_t rt,
                                    input logic [7:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t jType(input logic [11:0] target);
        return {`OP_JMP, target};
    endfunction

    function automatic word_t wwdInstr(input regIdx_t rs);
        return rType(rs, 2'd0, 2'd0, `FN_WWD);
    endfunction

    function automatic word_t haltInstr();
        return rType(2'd0, 2'd0, 2'd0, `FN_HLT);
    endfunction

    task automatic addInstr(input int t, input word_t w);
        progTab[t][progLen[t]] = w;
        progLen[t]++;
    endtask

    task automatic expectWwd(input int t, input word_t v);
        wwdTab[t][wwdNum[t]] = v;
        wwdNum[t]++;
    endtask

    task automatic buildTable();
        for (int t = 0; t < NUM_TESTS; t++) begin
            progLen[t] = 0;
            wwdNum[t] = 0;
            dataTab[t] = 16'h0000;
            for (int i = 0; i < PROG_WORDS; i++) begin
                progTab[t][i] = '0;
            end
            for (int i = 0; i < MAX_WWD; i++) begin
                wwdTab[t][i] = '0;
            end
        end

        // Dependent ALU chain forwarding from EX/MEM and MEM/WB
        testName[0] = "alu_forwarding";
        addInstr(0, iType(`OP_ADI, 2'd0, 2'd1, 8'd12));
        addInstr(0, iType(`OP_ADI, 2'd0, 2'd2, 8'd10));
        addInstr(0, rType(2'd1, 2'd2, 2'd3, `FN_ADD));
        addInstr(0, wwdInstr(2'd3));
        addInstr(0, rType(2'd3, 2'd2, 2'd3, `FN_SUB));
        addInstr(0, rType(2'd3, 2'd2, 2'd3, `FN_AND));
        addInstr(0, wwdInstr(2'd3));
        addInstr(0, rType(2'd3, 2'd2, 2'd3, `FN_ORR));
        addInstr(0, wwdInstr(2'd3));
        addInstr(0, rType(2'd3, 2'd1, 2'd3, `FN_SUB));
        addInstr(0, wwdInstr(2'd3));
        addInstr(0, haltInstr());
        expectWwd(0, 16'h0016);
        expectWwd(0, 16'h0008);
        expectWwd(0, 16'h000A);
        expectWwd(0, 16'hFFFE);
        countTab[0] = 16'd12;

        testName[1] = "adi_lhi";
        addInstr(1, iType(`OP_LHI, 2'd0, 2'd1, 8'h12));
        addInstr(1, iType(`OP_ADI, 2'd1, 2'd1, 8'h34));
        addInstr(1, wwdInstr(2'd1));
        addInstr(1, iType(`OP_ADI, 2'd0, 2'd2, 8'hF0));
        addInstr(1, wwdInstr(2'd2));
        addInstr(1, iType(`OP_ADI, 2'd2, 2'd2, 8'h7F));
        addInstr(1, wwdInstr(2'd2));
        addInstr(1, iType(`OP_LHI, 2'd0, 2'd3, 8'hA5));
        addInstr(1, wwdInstr(2'd3));
        addInstr(1, haltInstr());
        expectWwd(1, 16'h1234);
        expectWwd(1, 16'hFFF0);
        expectWwd(1, 16'h006F);
        expectWwd(1, 16'hA500);
        countTab[1] = 16'd10;

        // Two load-use stalls whose bubbles do not retire
        testName[2] = "load_use";
        dataTab[2] = 16'hBEEF;
        addInstr(2, iType(`OP_LWD, 2'd0, 2'd1, DATA_ADDR));
        addInstr(2, rType(2'd1, 2'd1, 2'd2, `FN_ADD));
        addInstr(2, wwdInstr(2'd2));
        addInstr(2, iType(`OP_SWD, 2'd0, 2'd2, 8'h11));
        addInstr(2, iType(`OP_LWD, 2'd0, 2'd3, 8'h11));
        addInstr(2, iType(`OP_ADI, 2'd3, 2'd3, 8'h01));
        addInstr(2, wwdInstr(2'd3));
        addInstr(2, wwdInstr(2'd1));
        addInstr(2, haltInstr());
        expectWwd(2, 16'h7DDE);
        expectWwd(2, 16'h7DDF);
        expectWwd(2, 16'hBEEF);
        countTab[2] = 16'd9;

        // Taken BEQ skips words 3 and 4 and BNE falls through
        testName[3] = "branches";
        addInstr(3, iType(`OP_ADI, 2'd0, 2'd1, 8'd7));
        addInstr(3, iType(`OP_ADI, 2'd0, 2'd2, 8'd7));
        addInstr(3, iType(`OP_BEQ, 2'd1, 2'd2, 8'd2));
        addInstr(3, iType(`OP_ADI, 2'd0, 2'd3, 8'h11));
        addInstr(3, wwdInstr(2'd3));
        addInstr(3, iType(`OP_BNE, 2'd1, 2'd2, 8'd2));
        addInstr(3, iType(`OP_ADI, 2'd0, 2'd3, 8'h22));
        addInstr(3, wwdInstr(2'd3));
        addInstr(3, iType(`OP_ADI, 2'd1, 2'd1, 8'd1));
        addInstr(3, wwdInstr(2'd1));
        addInstr(3, haltInstr());
        expectWwd(3, 16'h0022);
        expectWwd(3, 16'h0008);
        countTab[3] = 16'd9;

        testName[4] = "jump";
        addInstr(4, iType(`OP_ADI, 2'd0, 2'd1, 8'h33));
        addInstr(4, jType(12'd3));
        addInstr(4, iType(`OP_ADI, 2'd0, 2'd1, 8'h44));
        addInstr(4, wwdInstr(2'd1));
        addInstr(4, iType(`OP_ADI, 2'd1, 2'd2, 8'h10));
        addInstr(4, wwdInstr(2'd2));
        addInstr(4, haltInstr());
        expectWwd(4, 16'h0033);
        expectWwd(4, 16'h0043);
        countTab[4] = 16'd6;

        // Words behind HLT must never reach the output port
        testName[5] = "halt";
        addInstr(5, iType(`OP_ADI, 2'd0, 2'd1, 8'h5A));
        addInstr(5, wwdInstr(2'd1));
        addInstr(5, haltInstr());
        addInstr(5, iType(`OP_ADI, 2'd0, 2'd1, 8'h66));
        addInstr(5, wwdInstr(2'd1));
        expectWwd(5, 16'h005A);
        countTab[5] = 16'd3;
    endtask

    task automatic checkWord(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            valueErrors++;
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic checkCount(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            valueErrors++;
            $display("Fail %s count: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic checkFlag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            valueErrors++;
            $display("Fail %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    task automatic watchOutput(input int t, inout word_t lastOut, inout int seen);
        if (outputPort !== lastOut) begin
            if (seen < wwdNum[t]) begin
                checkWord($sformatf("%s wwd%0d", testName[t], seen), wwdTab[t][seen],
                          outputPort);
            end else begin
                otherErrors++;
                $display("Error in %s: output port changed to %h after all expected values",
                         testName[t], outputPort);
            end
            seen++;
            lastOut = outputPort;
        end
    endtask

    task automatic runTest(input int t);
        word_t lastOut;
        int seen;
        @(posedge Clk);
        curTest = t;
        rstN <= 1'b0;
        @(negedge Clk);
        for (int i = 0; i < PROG_WORDS; i++) begin
            rom[i] = progTab[t][i];
        end
        repeat (RESET_CYCLES) @(posedge Clk);
        rstN <= 1'b1;

        lastOut = '0;
        seen = 0;
        while (!isHalted) begin
            @(negedge Clk);
            watchOutput(t, lastOut, seen);
        end
        // Keep watching since nothing may move after halt
        repeat (SETTLE_CYCLES) begin
            @(negedge Clk);
            watchOutput(t, lastOut, seen);
        end

        if (seen < wwdNum[t]) begin
            otherErrors++;
            $display("Error in %s: only %0d of %0d output values appeared",
                     testName[t], seen, wwdNum[t]);
        end
        checkCount(testName[t], countTab[t], numInst);
        checkFlag({testName[t], " imemRead"}, 1'b0, imemRead);
    endtask

    initial begin
        Clk = 1'b0;
        rstN = 1'b0;
        curTest = 0;
        valueErrors = 0;
        otherErrors = 0;
        buildTable();
        for (int t = 0; t < NUM_TESTS; t++) begin
            runTest(t);
        end
        otherErrors += u_cpuCore.u_assertions.failCount;
        $display("Errors: %0d value mismatches, %0d other failures", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
        $display("Timeout: the core did not halt within %0d cycles",
                 NUM_TESTS * CYCLES_PER_TEST);
        $display("Errors: %0d value mismatches, %0d other failures", valueErrors,
                 otherErrors + 1 + u_cpuCore.u_assertions.failCount);
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/cpuCore.sv
`default_nettype none

module cpuCore (
    input  wire                 Clk,
    input  wire                 rstN,
    output logic                imemRead,
    output cpu_pkg::word_t      imemAddr,
    input  wire cpu_pkg::word_t imemData,
    output logic                dmemRead,
    output logic                dmemWrite,
    output cpu_pkg::word_t      dmemAddr,
    output cpu_pkg::word_t      dmemWdata,
    input  wire cpu_pkg::word_t dmemRdata,
    output logic                isHalted,
    output cpu_pkg::word_t      numInst,
    output cpu_pkg::word_t      outputPort
);
    import cpu_pkg::*;

    ifId_t ifIdIn, ifIdOut;
    idEx_t decoded, idExIn, idExOut;
    exMem_t exMemIn, exMemOut;
    memWb_t memWbIn, memWbOut;
    logic ifIdValid, idExValid, exMemValid, memWbValid;
    logic stall, flushIfId, flushIdEx, loadUse;
    logic takenBranch, jumpValid, haltRetire, haltFlush;
    word_t branchTarget, jumpTarget;
    word_t readData1, readData2, wbData;

    assign haltRetire = memWbValid && memWbOut.ctrl.isHalt;
    // Instructions younger than HLT never retire
    assign haltFlush = haltRetire || isHalted;

    pipeControl u_pipeControl (
        .Clk, .rstN, .loadUse, .takenBranch, .branchTarget,
        .jumpValid, .jumpTarget, .haltRetire,
        .pc(imemAddr), .imemRead, .stall, .flushIfId, .flushIdEx, .isHalted
    );

    assign ifIdIn = '{pc: imemAddr, instr: imemData};

    pipeStage #(.payloadT(ifId_t)) u_ifIdStage (
        .Clk, .rstN, .hold(stall), .flush(flushIfId),
        .inValid(imemRead), .inData(ifIdIn), .outValid(ifIdValid), .outData(ifIdOut)
    );

    instDecode u_instDecode (
        .ifId(ifIdOut), .ifIdValid, .idExRd(idExOut.rd),
        .idExMemRead(idExOut.ctrl.memRead), .idExValid,
        .decoded, .loadUse, .jumpValid, .jumpTarget
    );

    regFile u_regFile (
        .Clk, .rstN, .rs(decoded.rs), .rt(decoded.rt),
        .wb(memWbOut), .wbValid(memWbValid), .readData1, .readData2, .wbData
    );

    assign idExIn = '{
        pc: decoded.pc,
        ctrl: decoded.ctrl,
        readData1: readData1,
        readData2: readData2,
        rs: decoded.rs,
        rt: decoded.rt,
        rd: decoded.rd,
        imm: decoded.imm,
        opcode: decoded.opcode
    };

    pipeStage #(.payloadT(idEx_t)) u_idExStage (
        .Clk, .rstN, .hold(1'b0), .flush(flushIdEx),
        .inValid(ifIdValid), .inData(idExIn), .outValid(idExValid), .outData(idExOut)
    );

    execUnit u_execUnit (
        .idEx(idExOut), .idExValid, .exMem(exMemOut), .exMemValid,
        .wbData, .wbRd(memWbOut.rd), .wbWrite(memWbValid && memWbOut.ctrl.regWrite),
        .result(exMemIn), .takenBranch, .branchTarget
    );

    pipeStage #(.payloadT(exMem_t)) u_exMemStage (
        .Clk, .rstN, .hold(1'b0), .flush(haltFlush),
        .inValid(idExValid), .inData(exMemIn), .outValid(exMemValid), .outData(exMemOut)
    );

    assign dmemRead = exMemValid && exMemOut.ctrl.memRead;
    assign dmemWrite = exMemValid && exMemOut.ctrl.memWrite;
    assign dmemAddr = exMemOut.aluResult;
    assign dmemWdata = exMemOut.storeData;

    assign memWbIn = '{
        ctrl: exMemOut.ctrl,
        aluResult: exMemOut.aluResult,
        loadData: dmemRdata,
        rd: exMemOut.rd
    };

    pipeStage #(.payloadT(memWb_t)) u_memWbStage (
        .Clk, .rstN, .hold(1'b0), .flush(haltFlush),
        .inValid(exMemValid), .inData(memWbIn), .outValid(memWbValid), .outData(memWbOut)
    );

    retireCounter u_retireCounter (
        .Clk, .rstN, .retire(memWbValid), .isWwd(memWbOut.ctrl.isWwd),
        .wwdValue(memWbOut.aluResult), .numInst, .outputPort
    );

endmodule

`default_nettype wire

// File: logic/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Datapath sizes
`define WORD_SIZE 16
`define REG_COUNT 4

// Opcode field, instr[15:12]
`define OP_BNE 4'd0
`define OP_BEQ 4'd1
`define OP_ADI 4'd4
`define OP_LHI 4'd6
`define OP_LWD 4'd7
`define OP_SWD 4'd8
`define OP_JMP 4'd9
`define OP_RTYPE 4'd15

// Function field of R-type, instr[5:0]
`define FN_ADD 6'd0
`define FN_SUB 6'd1
`define FN_AND 6'd2
`define FN_ORR 6'd3
`define FN_WWD 6'd28
`define FN_HLT 6'd29

`endif

// File: logic/cpu_pkg.sv
`default_nettype none
`include "cpu_consts.svh"

package cpu_pkg;

    typedef logic [`WORD_SIZE-1:0] word_t;
    typedef logic [$clog2(`REG_COUNT)-1:0] regIdx_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_PASSA
    } aluOp_t;

    typedef struct packed {
        logic regWrite;
        logic memToReg;
        logic memWrite;
        logic memRead;
        logic isBranch;
        logic isWwd;
        logic isHalt;
        logic aluSrcImm;
        logic isLhi;
        aluOp_t aluOp;
    } ctrl_t;

    typedef struct packed {
        word_t pc;
        word_t instr;
    } ifId_t;

    typedef struct packed {
        word_t pc;
        ctrl_t ctrl;
        word_t readData1;
        word_t readData2;
        regIdx_t rs;
        regIdx_t rt;
        regIdx_t rd;
        word_t imm;
        logic [3:0] opcode;
    } idEx_t;

    // Store data rides along with the address in aluResult
    typedef struct packed {
        ctrl_t ctrl;
        word_t aluResult;
        word_t storeData;
        regIdx_t rd;
    } exMem_t;

    typedef struct packed {
        ctrl_t ctrl;
        word_t aluResult;
        word_t loadData;
        regIdx_t rd;
    } memWb_t;

endpackage

`default_nettype wire

// File: logic/execUnit.sv
`default_nettype none
`include "cpu_consts.svh"

module execUnit (
    input  wire cpu_pkg::idEx_t     idEx,
    input  wire                     idExValid,
    input  wire cpu_pkg::exMem_t    exMem,
    input  wire                     exMemValid,
    input  wire cpu_pkg::word_t     wbData,
    input  wire cpu_pkg::regIdx_t   wbRd,
    input  wire                     wbWrite,
    output cpu_pkg::exMem_t         result,
    output logic                    takenBranch,
    output cpu_pkg::word_t          branchTarget
);
    import cpu_pkg::*;

    word_t opA;
    word_t opB;
    word_t aluB;
    word_t aluOut;
    logic exWrite;
    logic equal;

    // EX/MEM is the younger producer, so it is checked first
    assign exWrite = exMemValid && exMem.ctrl.regWrite;
    assign opA = (exWrite && exMem.rd == idEx.rs) ? exMem.aluResult :
                 (wbWrite && wbRd == idEx.rs) ? wbData : idEx.readData1;
    assign opB = (exWrite && exMem.rd == idEx.rt) ? exMem.aluResult :
                 (wbWrite && wbRd == idEx.rt) ? wbData : idEx.readData2;

    assign aluB = idEx.ctrl.aluSrcImm ? idEx.imm : opB;

    always_comb begin
        case (idEx.ctrl.aluOp)
            ALU_SUB: aluOut = opA - aluB;
            ALU_AND: aluOut = opA & aluB;
            ALU_OR: aluOut = opA | aluB;
            ALU_PASSA: aluOut = opA;
            default: aluOut = opA + aluB;
        endcase
    end

    assign result = '{
        ctrl: idEx.ctrl,
        aluResult: idEx.ctrl.isLhi ? {idEx.imm[7:0], 8'h00} : aluOut,
        storeData: opB,
        rd: idEx.rd
    };

    assign equal = (opA == opB);
    // BEQ takes on equal, BNE on not equal
    assign takenBranch = idExValid && idEx.ctrl.isBranch &&
                         ((idEx.opcode == `OP_BEQ) == equal);
    assign branchTarget = idEx.pc + 1'b1 + idEx.imm;

endmodule

`default_nettype wire

// File: logic/instDecode.sv
`default_nettype none
`include "cpu_consts.svh"

module instDecode (
    input  wire cpu_pkg::ifId_t     ifId,
    input  wire                     ifIdValid,
    input  wire cpu_pkg::regIdx_t   idExRd,
    input  wire                     idExMemRead,
    input  wire                     idExValid,
    output cpu_pkg::idEx_t          decoded,
    output logic                    loadUse,
    output logic                    jumpValid,
    output cpu_pkg::word_t          jumpTarget
);
    import cpu_pkg::*;

    logic [3:0] opcode;
    logic [5:0] func;
    logic [7:0] immField;
    regIdx_t rs;
    regIdx_t rt;
    regIdx_t rdField;
    ctrl_t ctrl;
    logic useRs;
    logic useRt;

    assign opcode = ifId.instr[15:12];
    assign rs = ifId.instr[11:10];
    assign rt = ifId.instr[9:8];
    assign rdField = ifId.instr[7:6];
    assign func = ifId.instr[5:0];
    assign immField = ifId.instr[7:0];

    always_comb begin
        ctrl = '0;
        useRs = 1'b0;
        useRt = 1'b0;
        case (opcode)
            `OP_RTYPE: begin
                useRs = 1'b1;
                case (func)
                    `FN_ADD, `FN_SUB, `FN_AND, `FN_ORR: begin
                        useRt = 1'b1;
                        ctrl.regWrite = 1'b1;
                    end
                    `FN_WWD: ctrl.isWwd = 1'b1;
                    `FN_HLT: begin
                        useRs = 1'b0;
                        ctrl.isHalt = 1'b1;
                    end
                    default: ;
                endcase
                case (func)
                    `FN_SUB: ctrl.aluOp = ALU_SUB;
                    `FN_AND: ctrl.aluOp = ALU_AND;
                    `FN_ORR: ctrl.aluOp = ALU_OR;
                    `FN_WWD: ctrl.aluOp = ALU_PASSA;
                    default: ctrl.aluOp = ALU_ADD;
                endcase
            end
            `OP_ADI: begin
                useRs = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            `OP_LHI: begin
                ctrl.regWrite = 1'b1;
                ctrl.isLhi = 1'b1;
            end
            `OP_LWD: begin
                useRs = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.memRead = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            `OP_SWD: begin
                useRs = 1'b1;
                useRt = 1'b1;
                ctrl.memWrite = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            `OP_BNE, `OP_BEQ: begin
                useRs = 1'b1;
                useRt = 1'b1;
                ctrl.isBranch = 1'b1;
            end
            default: ;
        endcase
    end

    // I-type results land in rt
    assign decoded = '{
        pc: ifId.pc,
        ctrl: ctrl,
        readData1: '0,
        readData2: '0,
        rs: rs,
        rt: rt,
        rd: (opcode == `OP_RTYPE) ? rdField : rt,
        imm: {{8{immField[7]}}, immField},
        opcode: opcode
    };

    assign loadUse = ifIdValid && idExValid && idExMemRead &&
                     ((useRs && idExRd == rs) || (useRt && idExRd == rt));

    assign jumpValid = ifIdValid && (opcode == `OP_JMP);
    assign jumpTarget = {ifId.pc[`WORD_SIZE-1:12], ifId.instr[11:0]};

endmodule

`default_nettype wire

// File: logic/pipeControl.sv
`default_nettype none

module pipeControl (
    input  wire                 Clk,
    input  wire                 rstN,
    input  wire                 loadUse,
    input  wire                 takenBranch,
    input  wire cpu_pkg::word_t branchTarget,
    input  wire                 jumpValid,
    input  wire cpu_pkg::word_t jumpTarget,
    input  wire                 haltRetire,
    output cpu_pkg::word_t      pc,
    output logic                imemRead,
    output logic                stall,
    output logic                flushIfId,
    output logic                flushIdEx,
    output logic                isHalted
);
    import cpu_pkg::*;

    typedef enum logic {RUN, HALTED} state_t;

    state_t state;
    state_t stateNext;
    word_t pcNext;
    logic haltNow;

    assign isHalted = (state == HALTED);
    assign imemRead = (state == RUN);
    // Halt takes effect on the retire edge of HLT
    assign haltNow = haltRetire || isHalted;

    assign stall = loadUse && !haltNow;
    assign flushIfId = takenBranch || jumpValid || haltNow;
    // A stall turns the ID/EX load into a bubble
    assign flushIdEx = takenBranch || stall || haltNow;

    always_comb begin
        case (state)
            RUN: stateNext = haltRetire ? HALTED : RUN;
            default: stateNext = HALTED;
        endcase
    end

    always_comb begin
        if (haltNow) begin
            pcNext = pc;
        end else if (takenBranch) begin
            pcNext = branchTarget;
        end else if (jumpValid) begin
            pcNext = jumpTarget;
        end else if (stall) begin
            pcNext = pc;
        end else begin
            pcNext = pc + 1'b1;
        end
    end

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            state <= RUN;
            pc <= '0;
        end else begin
            state <= stateNext;
            pc <= pcNext;
        end
    end

endmodule

`default_nettype wire

// File: logic/pipeStage.sv
`default_nettype none

module pipeStage #(
    parameter type payloadT = logic
) (
    input  wire          Clk,
    input  wire          rstN,
    input  wire          hold,
    input  wire          flush,
    input  wire          inValid,
    input  wire payloadT inData,
    output logic         outValid,
    output payloadT      outData
);

    // Flush wins over hold
    always_ff @(posedge Clk) begin
        if (!rstN) begin
            outValid <= 1'b0;
        end else if (flush) begin
            outValid <= 1'b0;
        end else if (!hold) begin
            outValid <= inValid;
        end
    end

    always_ff @(posedge Clk) begin
        if (flush || !hold) begin
            outData <= inData;
        end
    end

endmodule

`default_nettype wire

// File: logic/regFile.sv
`default_nettype none
`include "cpu_consts.svh"

module regFile (
    input  wire                     Clk,
    input  wire                     rstN,
    input  wire cpu_pkg::regIdx_t   rs,
    input  wire cpu_pkg::regIdx_t   rt,
    input  wire cpu_pkg::memWb_t    wb,
    input  wire                     wbValid,
    output cpu_pkg::word_t          readData1,
    output cpu_pkg::word_t          readData2,
    output cpu_pkg::word_t          wbData
);
    import cpu_pkg::*;

    word_t regs [`REG_COUNT];
    logic wbWrite;

    assign wbData = wb.ctrl.memToReg ? wb.loadData : wb.aluResult;
    assign wbWrite = wbValid && wb.ctrl.regWrite;

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wbWrite) begin
            regs[wb.rd] <= wbData;
        end
    end

    // Write-through so decode sees the value being written back
    assign readData1 = (wbWrite && wb.rd == rs) ? wbData : regs[rs];
    assign readData2 = (wbWrite && wb.rd == rt) ? wbData : regs[rt];

endmodule

`default_nettype wire

// File: logic/retireCounter.sv
`default_nettype none

module retireCounter (
    input  wire                 Clk,
    input  wire                 rstN,
    input  wire                 retire,
    input  wire                 isWwd,
    input  wire cpu_pkg::word_t wwdValue,
    output cpu_pkg::word_t      numInst,
    output cpu_pkg::word_t      outputPort
);

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            numInst <= '0;
            outputPort <= '0;
        end else if (retire) begin
            numInst <= numInst + 1'b1;
            // WWD value shows up on the same edge it is counted
            if (isWwd) begin
                outputPort <= wwdValue;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+logic
logic/cpu_pkg.sv
logic/pipeStage.sv
logic/pipeControl.sv
logic/retireCounter.sv
logic/regFile.sv
logic/instDecode.sv
logic/execUnit.sv
logic/cpuCore.sv
bench/cpuCore_assertions.sv
bench/cpuCore_tb.sv
